//--- verilog/mm_pkg.sv
/*
 * Shared constants and types for the integer matrix-multiply accelerator.
 * Import with a wildcard in the module header of any block that needs
 * the tile geometry, element widths or the row types.
 */

package mm_pkg;

  // Tile geometry and element widths
  localparam int unsigned TILE_N = 4;
  localparam int unsigned ELEM_W = 8;
  localparam int unsigned ACC_W  = 20;

  // Full-precision width of one signed operand product
  localparam int unsigned PROD_W = 2 * ELEM_W;

  // Stream buffering
  localparam int unsigned IN_FIFO_DEPTH  = 4;
  localparam int unsigned OUT_FIFO_DEPTH = 2;

  // Job length of 1 to 255 rows
  localparam int unsigned ROWS_W = 8;

  // Named signed elements keep their sign when picked out of a row
  typedef logic signed [ELEM_W-1:0] op_elem_t;
  typedef logic signed [ACC_W-1:0]  acc_elem_t;

  // One X or W row
  typedef op_elem_t [TILE_N-1:0] op_row_t;

  // One Y or Z row that wraps modulo 2^ACC_W
  typedef acc_elem_t [TILE_N-1:0] acc_row_t;

  // Weight tile indexed [k][j]
  typedef op_row_t [TILE_N-1:0] w_tile_t;

  // X row and its bias row issued together to the MAC array
  typedef struct packed {
    op_row_t  x;
    acc_row_t y;
  } issue_t;

endpackage : mm_pkg

//--- verilog/stream_fifo.sv
/*
 * Valid/ready FIFO with a type parameter for its payload.
 * Circular buffer with read and write pointers and an occupancy count;
 * clear_i empties it. Used for the X, W, Y and Z row streams.
 */

`timescale 1ns/1ps

module stream_fifo
  import mm_pkg::*;
#(
  parameter type         T     = op_row_t,
  parameter int unsigned DEPTH = IN_FIFO_DEPTH
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic clear_i,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];

  // A full FIFO still accepts a push when the head leaves in the same cycle
  assign push_ready_o = (count_q != CNT_W'(DEPTH)) || pop_ready_i;

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : stream_fifo

//--- verilog/w_buffer.sv
/*
 * Weight tile buffer. Collects TILE_N W rows in order, then holds the
 * tile for the rest of the job. start_i restarts the fill at row 0.
 */

`timescale 1ns/1ps

module w_buffer
  import mm_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    clear_i,
  input  logic    start_i,
  input  logic    load_i,
  input  op_row_t row_i,
  output w_tile_t w_tile_o,
  output logic    w_full_o
);

  localparam int unsigned IDX_W = $clog2(TILE_N);

  logic [IDX_W-1:0] fill_idx_q;
  logic             take;

  // Extra rows are refused once the tile is complete
  assign take = load_i && !w_full_o;

  always_ff @(posedge clk_i) begin
    if (take) begin
      w_tile_o[fill_idx_q] <= row_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fill_idx_q <= '0;
      w_full_o   <= 1'b0;
    end else if (clear_i || start_i) begin
      fill_idx_q <= '0;
      w_full_o   <= 1'b0;
    end else if (take) begin
      fill_idx_q <= fill_idx_q + IDX_W'(1);
      // Last row of the tile stored
      if (fill_idx_q == IDX_W'(TILE_N - 1)) begin
        w_full_o <= 1'b1;
      end
    end
  end

endmodule : w_buffer

//--- verilog/mac_array.sv
/*
 * Two-stage multiply-accumulate pipe for one Z row per issue.
 * Stage 1 registers all x[k]*W[k][j] products and the bias row, stage 2
 * registers the column sums plus bias and is the output register.
 * The whole pipe holds while the output row is not accepted.
 */

`timescale 1ns/1ps

module mac_array
  import mm_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     clear_i,
  input  logic     in_valid_i,
  input  issue_t   in_i,
  output logic     in_ready_o,
  input  w_tile_t  w_tile_i,
  output logic     z_valid_o,
  output acc_row_t z_row_o,
  input  logic     z_ready_i
);

  logic                     stall;
  logic                     s1_valid_q;
  logic signed [PROD_W-1:0] s1_prod_q [TILE_N][TILE_N];
  acc_row_t                 s1_bias_q;
  acc_row_t                 z_sum;

  // Output row held and not taken freezes both stages
  assign stall      = z_valid_o && !z_ready_i;
  assign in_ready_o = !stall;

  // Stage 1 products indexed [k][j]
  always_ff @(posedge clk_i) begin
    if (!stall && in_valid_i) begin
      for (int k = 0; k < TILE_N; k++) begin
        for (int j = 0; j < TILE_N; j++) begin
          s1_prod_q[k][j] <= $signed(in_i.x[k]) * $signed(w_tile_i[k][j]);
        end
      end
      s1_bias_q <= in_i.y;
    end
  end

  // Column sums where the signed adds wrap at ACC_W bits
  always_comb begin
    acc_elem_t acc;
    for (int j = 0; j < TILE_N; j++) begin
      acc = s1_bias_q[j];
      for (int k = 0; k < TILE_N; k++) begin
        acc = acc + s1_prod_q[k][j];
      end
      z_sum[j] = acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall && s1_valid_q) begin
      z_row_o <= z_sum;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
      z_valid_o  <= 1'b0;
    end else if (clear_i) begin
      s1_valid_q <= 1'b0;
      z_valid_o  <= 1'b0;
    end else if (!stall) begin
      s1_valid_q <= in_valid_i;
      z_valid_o  <= s1_valid_q;
    end
  end

endmodule : mac_array

//--- verilog/scheduler.sv
/*
 * Job control FSM. A trigger while idle latches the row count and starts
 * the weight load, then X/Y rows are issued to the MAC array until the
 * job count is reached. The last accepted Z row ends the job with evt_o.
 */

`timescale 1ns/1ps

module scheduler
  import mm_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              clear_i,
  input  logic              trigger_i,
  input  logic [ROWS_W-1:0] n_rows_i,
  input  logic              w_full_i,
  input  logic              x_valid_i,
  input  logic              y_valid_i,
  input  logic              mac_ready_i,
  input  logic              z_done_i,
  output logic              w_start_o,
  output logic              w_load_o,
  output logic              issue_o,
  output logic              busy_o,
  output logic              evt_o
);

  typedef enum logic [1:0] {
    IDLE,
    LOAD_W,
    RUN,
    DONE
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic [ROWS_W-1:0] n_rows_q;
  logic [ROWS_W-1:0] issued_q;
  logic [ROWS_W-1:0] done_q;
  logic              last_done;

  // Trigger only counts while idle
  assign w_start_o = (state_q == IDLE) && trigger_i;
  assign w_load_o  = (state_q == LOAD_W) && !w_full_i;

  // Issue strobe doubles as the X and Y pop
  assign issue_o = (state_q == RUN) && w_full_i && x_valid_i && y_valid_i &&
                   mac_ready_i && (issued_q != n_rows_q);

  assign last_done = (state_q == RUN) && z_done_i &&
                     (done_q == n_rows_q - ROWS_W'(1));

  assign busy_o = (state_q == LOAD_W) || (state_q == RUN);
  assign evt_o  = (state_q == DONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (trigger_i) state_d = LOAD_W;
      LOAD_W:  if (w_full_i) state_d = RUN;
      RUN:     if (last_done) state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      n_rows_q <= '0;
      issued_q <= '0;
      done_q   <= '0;
    end else if (clear_i) begin
      // Aborts a running job without an event
      state_q  <= IDLE;
      n_rows_q <= '0;
      issued_q <= '0;
      done_q   <= '0;
    end else begin
      state_q <= state_d;
      if (w_start_o) begin
        n_rows_q <= n_rows_i;
        issued_q <= '0;
        done_q   <= '0;
      end else begin
        if (issue_o) begin
          issued_q <= issued_q + ROWS_W'(1);
        end
        if ((state_q == RUN) && z_done_i) begin
          done_q <= done_q + ROWS_W'(1);
        end
      end
    end
  end

endmodule : scheduler

//--- verilog/mm_top.sv
/*
 * Matrix-multiply accelerator top level, Z = X*W + Y per row.
 * Stream FIFOs on X, W, Y and Z, a weight tile buffer, the job scheduler
 * and the MAC array. soft_clear_i empties everything and aborts a job.
 */

`timescale 1ns/1ps

module mm_top
  import mm_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              x_valid_i,
  input  op_row_t           x_data_i,
  output logic              x_ready_o,
  input  logic              w_valid_i,
  input  op_row_t           w_data_i,
  output logic              w_ready_o,
  input  logic              y_valid_i,
  input  acc_row_t          y_data_i,
  output logic              y_ready_o,
  output logic              z_valid_o,
  output acc_row_t          z_data_o,
  input  logic              z_ready_i,
  input  logic              trigger_i,
  input  logic [ROWS_W-1:0] n_rows_i,
  input  logic              soft_clear_i,
  output logic              busy_o,
  output logic              evt_o
);

  op_row_t  x_head;
  op_row_t  w_head;
  acc_row_t y_head;
  logic     x_head_valid;
  logic     w_head_valid;
  logic     y_head_valid;
  issue_t   issue;
  logic     issue_valid;
  w_tile_t  w_tile;
  logic     w_full;
  logic     w_start;
  logic     w_load;
  logic     w_take;
  logic     mac_ready;
  logic     z_push_valid;
  acc_row_t z_push_row;
  logic     z_push_ready;
  logic     z_done;

  assign issue.x = x_head;
  assign issue.y = y_head;
  assign w_take  = w_load && w_head_valid;
  assign z_done  = z_push_valid && z_push_ready;

  stream_fifo #(
    .T     ( op_row_t      ),
    .DEPTH ( IN_FIFO_DEPTH )
  ) i_x_fifo (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .clear_i      ( soft_clear_i ),
    .push_valid_i ( x_valid_i    ),
    .push_data_i  ( x_data_i     ),
    .push_ready_o ( x_ready_o    ),
    .pop_valid_o  ( x_head_valid ),
    .pop_data_o   ( x_head       ),
    .pop_ready_i  ( issue_valid  )
  );

  stream_fifo #(
    .T     ( op_row_t      ),
    .DEPTH ( IN_FIFO_DEPTH )
  ) i_w_fifo (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .clear_i      ( soft_clear_i ),
    .push_valid_i ( w_valid_i    ),
    .push_data_i  ( w_data_i     ),
    .push_ready_o ( w_ready_o    ),
    .pop_valid_o  ( w_head_valid ),
    .pop_data_o   ( w_head       ),
    .pop_ready_i  ( w_load       )
  );

  stream_fifo #(
    .T     ( acc_row_t     ),
    .DEPTH ( IN_FIFO_DEPTH )
  ) i_y_fifo (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .clear_i      ( soft_clear_i ),
    .push_valid_i ( y_valid_i    ),
    .push_data_i  ( y_data_i     ),
    .push_ready_o ( y_ready_o    ),
    .pop_valid_o  ( y_head_valid ),
    .pop_data_o   ( y_head       ),
    .pop_ready_i  ( issue_valid  )
  );

  stream_fifo #(
    .T     ( acc_row_t      ),
    .DEPTH ( OUT_FIFO_DEPTH )
  ) i_z_fifo (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .clear_i      ( soft_clear_i ),
    .push_valid_i ( z_push_valid ),
    .push_data_i  ( z_push_row   ),
    .push_ready_o ( z_push_ready ),
    .pop_valid_o  ( z_valid_o    ),
    .pop_data_o   ( z_data_o     ),
    .pop_ready_i  ( z_ready_i    )
  );

  w_buffer i_w_buffer (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .clear_i  ( soft_clear_i ),
    .start_i  ( w_start      ),
    .load_i   ( w_take       ),
    .row_i    ( w_head       ),
    .w_tile_o ( w_tile       ),
    .w_full_o ( w_full       )
  );

  scheduler i_scheduler (
    .clk_i       ( clk_i        ),
    .arst_n_i    ( arst_n_i     ),
    .clear_i     ( soft_clear_i ),
    .trigger_i   ( trigger_i    ),
    .n_rows_i    ( n_rows_i     ),
    .w_full_i    ( w_full       ),
    .x_valid_i   ( x_head_valid ),
    .y_valid_i   ( y_head_valid ),
    .mac_ready_i ( mac_ready    ),
    .z_done_i    ( z_done       ),
    .w_start_o   ( w_start      ),
    .w_load_o    ( w_load       ),
    .issue_o     ( issue_valid  ),
    .busy_o      ( busy_o       ),
    .evt_o       ( evt_o        )
  );

  mac_array i_mac_array (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .clear_i    ( soft_clear_i ),
    .in_valid_i ( issue_valid  ),
    .in_i       ( issue        ),
    .in_ready_o ( mac_ready    ),
    .w_tile_i   ( w_tile       ),
    .z_valid_o  ( z_push_valid ),
    .z_row_o    ( z_push_row   ),
    .z_ready_i  ( z_push_ready )
  );

endmodule : mm_top

//--- test/mm_checker.sv
/*
 * Protocol assertions for mm_top, attached to every mm_top by bind.
 * Covers Z stream stability under back-pressure, the end-of-job pulse
 * and the output state in the first cycle after reset.
 */

`timescale 1ns/1ps

module mm_checker
  import mm_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input logic     soft_clear_i,
  input logic     z_valid_i,
  input acc_row_t z_data_i,
  input logic     z_ready_i,
  input logic     busy_i,
  input logic     evt_i
);

  int unsigned fail_count = 0;

  // A held Z row stays put until taken unless a soft clear drops it
  z_stable_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (z_valid_i && !z_ready_i && !soft_clear_i) |=> (z_valid_i && $stable(z_data_i))
  ) else begin
    $error("Z row changed or dropped while z_ready was low");
    fail_count++;
  end

  // Single-cycle event with the job already idle afterwards
  evt_pulse_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    evt_i |=> (!evt_i && !busy_i)
  ) else begin
    $error("End-of-job event longer than one cycle or busy still high after it");
    fail_count++;
  end

  reset_out_a : assert property (
    @(posedge clk_i) $rose(arst_n_i) |-> (!busy_i && !evt_i && !z_valid_i)
  ) else begin
    $error("Outputs not idle in the first cycle after reset");
    fail_count++;
  end

endmodule : mm_checker

//--- test/tb_mm_top.sv
/*
 * Testbench for the matrix-multiply accelerator. Runs six jobs against a
 * row-level reference model with random back-pressure, a retrigger while
 * busy and a soft clear in mid-job. mm_checker is bound into the DUT.
 */

`timescale 1ns/1ps

module tb_mm_top
  import mm_pkg::*;
();

  localparam int unsigned CLK_HALF        = 10;
  localparam int unsigned TOTAL_ROWS      = 6 + 20 + 30 + 12 + 20 + 10;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_ROWS * 40 + 400;

  logic              clk_i;
  logic              arst_n_i;
  logic              x_valid_i;
  op_row_t           x_data_i;
  logic              x_ready_o;
  logic              w_valid_i;
  op_row_t           w_data_i;
  logic              w_ready_o;
  logic              y_valid_i;
  acc_row_t          y_data_i;
  logic              y_ready_o;
  logic              z_valid_o;
  acc_row_t          z_data_o;
  logic              z_ready_i;
  logic              trigger_i;
  logic [ROWS_W-1:0] n_rows_i;
  logic              soft_clear_i;
  logic              busy_o;
  logic              evt_o;

  w_tile_t     cur_w;
  op_row_t     x_q [$];
  acc_row_t    y_q [$];
  acc_row_t    exp_q [$];
  int unsigned bp_pct       = 0;
  bit          abort_feed   = 1'b0;
  int unsigned evt_count    = 0;
  int unsigned z_count      = 0;
  int unsigned errors       = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;

  mm_top i_mm_top (.*);

  bind mm_top mm_checker i_mm_checker (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .soft_clear_i ( soft_clear_i ),
    .z_valid_i    ( z_valid_o    ),
    .z_data_i     ( z_data_o     ),
    .z_ready_i    ( z_ready_i    ),
    .busy_i       ( busy_o       ),
    .evt_i        ( evt_o        )
  );

  initial clk_i = 1'b0;
  always #(CLK_HALF) clk_i = ~clk_i;

  // Random Z back-pressure with bp_pct percent of cycles not ready
  always @(posedge clk_i) begin
    #1;
    z_ready_i = (bp_pct == 0) || ($urandom_range(99) >= bp_pct);
  end

  // Z pop and event monitor sampled mid-cycle where everything is settled
  always @(negedge clk_i) begin
    acc_row_t exp_row;
    if (arst_n_i && !soft_clear_i && z_valid_o && z_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Z row %h arrived with no expected row pending", z_data_o);
      end else begin
        exp_row = exp_q.pop_front();
        z_count++;
        assert (z_data_o == exp_row) else begin
          errors++;
          $display("MISMATCH z_data_o=%h expected=%h", z_data_o, exp_row);
        end
      end
    end
    if (evt_o) begin
      evt_count++;
    end
  end

  // Z[j] = sum over k of x[k]*W[k][j] plus y[j], modulo 2^ACC_W
  function automatic acc_row_t model_row(op_row_t x, acc_row_t y, w_tile_t w);
    acc_row_t z;
    longint   sum;
    for (int j = 0; j < TILE_N; j++) begin
      sum = longint'(y[j]);
      for (int k = 0; k < TILE_N; k++) begin
        sum += longint'(x[k]) * longint'(w[k][j]);
      end
      z[j] = sum[ACC_W-1:0];
    end
    return z;
  endfunction

  function automatic op_row_t rand_op_row();
    op_row_t r;
    for (int j = 0; j < TILE_N; j++) begin
      r[j] = op_elem_t'($urandom);
    end
    return r;
  endfunction

  function automatic acc_row_t rand_acc_row();
    acc_row_t r;
    for (int j = 0; j < TILE_N; j++) begin
      r[j] = acc_elem_t'($urandom);
    end
    return r;
  endfunction

  function automatic w_tile_t rand_tile();
    w_tile_t t;
    for (int k = 0; k < TILE_N; k++) begin
      t[k] = rand_op_row();
    end
    return t;
  endfunction

  task automatic new_job();
    x_q.delete();
    y_q.delete();
  endtask

  task automatic add_row(op_row_t x, acc_row_t y);
    x_q.push_back(x);
    y_q.push_back(y);
    exp_q.push_back(model_row(x, y, cur_w));
  endtask

  task automatic start_job(int unsigned n);
    @(posedge clk_i);
    #1;
    trigger_i = 1'b1;
    n_rows_i  = ROWS_W'(n);
    @(posedge clk_i);
    #1;
    trigger_i = 1'b0;
  endtask

  // Pushes the W tile and all X/Y rows on their own handshakes
  task automatic feed_streams();
    int unsigned xi;
    int unsigned yi;
    int unsigned wi;
    bit          x_take;
    bit          y_take;
    bit          w_take;
    xi = 0;
    yi = 0;
    wi = 0;
    while (!abort_feed && (xi < x_q.size() || yi < y_q.size() || wi < TILE_N)) begin
      x_valid_i = (xi < x_q.size());
      y_valid_i = (yi < y_q.size());
      w_valid_i = (wi < TILE_N);
      if (x_valid_i) begin
        x_data_i = x_q[xi];
      end
      if (y_valid_i) begin
        y_data_i = y_q[yi];
      end
      if (w_valid_i) begin
        w_data_i = cur_w[wi];
      end
      @(negedge clk_i);
      x_take = x_valid_i && x_ready_o;
      y_take = y_valid_i && y_ready_o;
      w_take = w_valid_i && w_ready_o;
      @(posedge clk_i);
      #1;
      xi += x_take;
      yi += y_take;
      wi += w_take;
    end
    x_valid_i = 1'b0;
    y_valid_i = 1'b0;
    w_valid_i = 1'b0;
  endtask

  // Busy must hold until the event and every expected row must arrive
  task automatic wait_job(int unsigned evt_before);
    while (evt_count == evt_before || exp_q.size() != 0) begin
      @(negedge clk_i);
      if (evt_count == evt_before && !evt_o && !busy_o) begin
        errors++;
        $display("busy_o fell before the end-of-job event");
      end
    end
  endtask

  task automatic finish_test(string name, int unsigned err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic run_job(string name, int unsigned n, int unsigned bp, bit retrigger);
    int unsigned evt_before;
    int unsigned err_before;
    evt_before = evt_count;
    err_before = errors;
    bp_pct     = bp;
    abort_feed = 1'b0;
    start_job(n);
    fork
      feed_streams();
      wait_job(evt_before);
      if (retrigger) begin
        repeat (6) @(posedge clk_i);
        #1;
        start_job(n);
      end
    join
    repeat (10) @(negedge clk_i);
    if (evt_count != evt_before + 1) begin
      errors++;
      $display("Expected one end-of-job event, saw %0d", evt_count - evt_before);
    end
    if (busy_o) begin
      errors++;
      $display("busy_o still high well after the job ended");
    end
    finish_test(name, err_before);
  endtask

  initial begin
    op_row_t     xr;
    acc_row_t    yr;
    int unsigned evt_before;
    int unsigned err_before;
    void'($urandom(30117));
    arst_n_i     = 1'b0;
    x_valid_i    = 1'b0;
    x_data_i     = '0;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    y_valid_i    = 1'b0;
    y_data_i     = '0;
    z_ready_i    = 1'b0;
    trigger_i    = 1'b0;
    n_rows_i     = '0;
    soft_clear_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;

    // Identity tile with zero bias
    for (int k = 0; k < TILE_N; k++) begin
      for (int j = 0; j < TILE_N; j++) begin
        cur_w[k][j] = (k == j) ? op_elem_t'(1) : op_elem_t'(0);
      end
    end
    new_job();
    for (int r = 0; r < 6; r++) begin
      add_row(rand_op_row(), '0);
    end
    run_job("identity", 6, 0, 1'b0);

    // Random tile with column 0 forced to -128 so extreme rows wrap
    cur_w = rand_tile();
    for (int k = 0; k < TILE_N; k++) begin
      cur_w[k][0] = op_elem_t'(-128);
    end
    new_job();
    for (int r = 0; r < 20; r++) begin
      xr = rand_op_row();
      yr = rand_acc_row();
      for (int j = 0; j < TILE_N; j++) begin
        if (r % 5 == 0) begin
          xr[j] = op_elem_t'(-128);
          yr[j] = acc_elem_t'(20'h7FFFF);
        end else if (r % 5 == 1) begin
          xr[j] = op_elem_t'(127);
          yr[j] = acc_elem_t'(20'h80000);
        end
      end
      add_row(xr, yr);
    end
    run_job("random with wrap", 20, 0, 1'b0);

    cur_w = rand_tile();
    new_job();
    for (int r = 0; r < 30; r++) begin
      add_row(rand_op_row(), rand_acc_row());
    end
    run_job("back-pressure", 30, 60, 1'b0);

    cur_w = rand_tile();
    new_job();
    for (int r = 0; r < 12; r++) begin
      add_row(rand_op_row(), rand_acc_row());
    end
    run_job("retrigger while busy", 12, 0, 1'b1);

    // Abort a running job and check that nothing more comes out
    evt_before = evt_count;
    err_before = errors;
    cur_w      = rand_tile();
    new_job();
    for (int r = 0; r < 20; r++) begin
      add_row(rand_op_row(), rand_acc_row());
    end
    bp_pct     = 0;
    abort_feed = 1'b0;
    start_job(20);
    fork
      feed_streams();
      begin
        repeat (10) @(negedge clk_i);
        abort_feed = 1'b1;
      end
    join
    soft_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    soft_clear_i = 1'b0;
    exp_q.delete();
    repeat (10) @(negedge clk_i);
    if (evt_count != evt_before || busy_o || z_valid_o) begin
      errors++;
      $display("Activity after soft clear: event, busy or Z row seen");
    end
    finish_test("soft clear abort", err_before);

    cur_w = rand_tile();
    new_job();
    for (int r = 0; r < 10; r++) begin
      add_row(rand_op_row(), rand_acc_row());
    end
    run_job("job after clear", 10, 25, 1'b0);

    $display("tests %0d, failed %0d, z rows %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, z_count, errors, i_mm_top.i_mm_checker.fail_count);
    if (errors == 0 && tests_failed == 0 && i_mm_top.i_mm_checker.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Generous bound of 40 cycles per job row
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the jobs did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tb_mm_top

//--- build.f
verilog/mm_pkg.sv
verilog/stream_fifo.sv
verilog/w_buffer.sv
verilog/mac_array.sv
verilog/scheduler.sv
verilog/mm_top.sv
test/mm_checker.sv
test/tb_mm_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mm_top -f build.f --Mdir obj_dir

# A failing run must still reach the result check below
./obj_dir/Vtb_mm_top +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1
